/* common/cmdproc_params.svh */
`ifndef CMDPROC_PARAMS_SVH
`define CMDPROC_PARAMS_SVH

// operand and result width
`define CP_DATA_W 16

// command tag carried through to the response
`define CP_TAG_W 4

// command queue depth, also the host credit count after reset
`define CP_CMD_DEPTH 8

// response queue depth, also the decode credit count after reset
`define CP_RSP_DEPTH 4

// credits granted by the downstream consumer after reset
`define CP_RSP_CREDITS 2

`endif

/* common/cmd_pkg.sv */
`include "cmdproc_params.svh"

package cmd_pkg;

  // codes 5..7 are not assigned and decode as illegal
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_XOR = 3'd3,
    OP_SRL = 3'd4  // a >> b[3:0]
  } opcode_e;

  // 39-bit command as pushed by the host
  typedef struct packed {
    opcode_e                op;
    logic [`CP_DATA_W-1:0]  a;
    logic [`CP_DATA_W-1:0]  b;
    logic [`CP_TAG_W-1:0]   tag;
  } cmd_t;

  // decoded micro-op handed to execute
  typedef struct packed {
    cmd_t cmd;
    logic illegal;  // opcode outside the enum
  } uop_t;

endpackage

/* common/rsp_pkg.sv */
`include "cmdproc_params.svh"

package rsp_pkg;

  typedef enum logic [1:0] {
    ST_OK     = 2'd0,
    ST_BAD_OP = 2'd1
  } status_e;

  // 22-bit response returned to the consumer
  typedef struct packed {
    logic [`CP_TAG_W-1:0]   tag;
    logic [`CP_DATA_W-1:0]  result;
    status_e                status;
  } rsp_t;

endpackage

/* hw/credit_fifo.sv */
`timescale 1ns/1ps
`include "cmdproc_params.svh"

module credit_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = `CP_CMD_DEPTH
) (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_push,
  input  T     i_data,
  input  logic i_pop,
  output T     o_data,
  output logic o_empty,
  output logic o_full,
  output logic o_credit,
  output logic o_overrun
);

  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T               mem [DEPTH];
  logic [AW-1:0]  wr_ptr;
  logic [AW-1:0]  rd_ptr;
  logic [CNT_W-1:0] count;
  logic           do_push;
  logic           do_pop;

  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    if (ptr == AW'(DEPTH - 1)) begin
      return '0;  // wrap for depths that are not a power of two
    end
    return ptr + 1'b1;
  endfunction

  assign o_empty = (count == '0);
  assign o_full  = (count == CNT_W'(DEPTH));
  assign o_data  = mem[rd_ptr];  // head is visible without a register stage

  assign do_pop  = i_pop && !o_empty;
  assign do_push = i_push && (!o_full || do_pop);  // full queue still takes a push on a pop

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      o_credit  <= 1'b0;
      o_overrun <= 1'b0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
      count    <= count + CNT_W'(do_push) - CNT_W'(do_pop);
      o_credit <= do_pop;  // credit goes back one cycle after the item leaves
      if (i_push && !do_push) begin
        o_overrun <= 1'b1;  // sticky until reset and the write is lost
      end
    end
  end

  // credit flow keeps the reader from popping an empty queue
  a_no_pop_empty : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_pop |-> !o_empty);

  a_count_bound : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    count <= CNT_W'(DEPTH));

endmodule

/* hw/cmd_decode.sv */
`timescale 1ns/1ps
`include "cmdproc_params.svh"

module cmd_decode (
  input  logic          i_clk,
  input  logic          i_rst_n,
  input  cmd_pkg::cmd_t i_cmd,
  input  logic          i_cmd_empty,
  input  logic          i_slot_credit,
  output logic          o_pop,
  output logic          o_uop_valid,
  output cmd_pkg::uop_t o_uop
);

  import cmd_pkg::*;

  localparam int CRED_W = $clog2(`CP_RSP_DEPTH + 1);

  logic [CRED_W-1:0] credits;  // free slots reserved in the response queue
  logic              issue;
  logic              illegal;

  // one credit covers a uop from issue until it leaves the response queue
  assign issue = !i_cmd_empty && (credits != '0);
  assign o_pop = issue;

  assign illegal = (i_cmd.op > OP_SRL);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      credits     <= CRED_W'(`CP_RSP_DEPTH);
      o_uop_valid <= 1'b0;
    end else begin
      o_uop_valid <= issue;
      case ({issue, i_slot_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;  // both or neither
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (issue) begin
      o_uop.cmd     <= i_cmd;
      o_uop.illegal <= illegal;
    end
  end

  a_credit_bound : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    credits <= CRED_W'(`CP_RSP_DEPTH));

endmodule

/* hw/alu_execute.sv */
`timescale 1ns/1ps
`include "cmdproc_params.svh"

module alu_execute (
  input  logic          i_clk,
  input  logic          i_rst_n,
  input  logic          i_uop_valid,
  input  cmd_pkg::uop_t i_uop,
  output logic          o_rsp_valid,
  output rsp_pkg::rsp_t o_rsp
);

  import cmd_pkg::*;
  import rsp_pkg::*;

  logic [`CP_DATA_W-1:0] result;
  status_e               status;

  always_comb begin
    status = ST_OK;
    case (i_uop.cmd.op)
      OP_ADD:  result = i_uop.cmd.a + i_uop.cmd.b;  // wraps at data width
      OP_SUB:  result = i_uop.cmd.a - i_uop.cmd.b;
      OP_AND:  result = i_uop.cmd.a & i_uop.cmd.b;
      OP_XOR:  result = i_uop.cmd.a ^ i_uop.cmd.b;
      OP_SRL:  result = i_uop.cmd.a >> i_uop.cmd.b[3:0];
      default: result = '0;
    endcase
    if (i_uop.illegal) begin
      result = '0;
      status = ST_BAD_OP;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rsp_valid <= 1'b0;
    end else begin
      o_rsp_valid <= i_uop_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_uop_valid) begin
      o_rsp.tag    <= i_uop.cmd.tag;  // tag is passed through
      o_rsp.result <= result;
      o_rsp.status <= status;
    end
  end

endmodule

/* hw/rsp_result.sv */
`timescale 1ns/1ps
`include "cmdproc_params.svh"

module rsp_result (
  input  logic          i_clk,
  input  logic          i_rst_n,
  input  logic          i_rsp_valid,
  input  rsp_pkg::rsp_t i_rsp,
  input  logic          i_rsp_credit,
  output logic          o_rsp_valid,
  output rsp_pkg::rsp_t o_rsp,
  output logic          o_slot_credit
);

  import rsp_pkg::*;

  localparam int CRED_W = $clog2(`CP_RSP_CREDITS + 1);

  logic [CRED_W-1:0] out_credits;  // consumer grants not yet used
  rsp_t              head;
  logic              q_empty;
  logic              q_credit;
  logic              q_overrun;
  logic              can_send;
  logic              bypass;
  logic              pop;
  logic              push;
  logic              send;
  logic              bypass_q;

  assign can_send = (out_credits != '0);
  // an empty queue lets a fresh response go straight to the output register
  assign bypass   = can_send && q_empty && i_rsp_valid;
  assign pop      = can_send && !q_empty;
  assign push     = i_rsp_valid && !bypass;
  assign send     = bypass || pop;

  credit_fifo #(
    .T     (rsp_t),
    .DEPTH (`CP_RSP_DEPTH)
  ) u_rsp_fifo (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_push    (push),
    .i_data    (i_rsp),
    .i_pop     (pop),
    .o_data    (head),
    .o_empty   (q_empty),
    .o_full    (),
    .o_credit  (q_credit),
    .o_overrun (q_overrun)
  );

  // slot goes back to decode one cycle after the send on either path
  assign o_slot_credit = q_credit || bypass_q;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      out_credits <= CRED_W'(`CP_RSP_CREDITS);
      o_rsp_valid <= 1'b0;
      bypass_q    <= 1'b0;
    end else begin
      o_rsp_valid <= send;
      bypass_q    <= bypass;
      out_credits <= out_credits - CRED_W'(send) + CRED_W'(i_rsp_credit);
    end
  end

  always_ff @(posedge i_clk) begin
    if (send) begin
      o_rsp <= pop ? head : i_rsp;  // queued items go first to keep order
    end
  end

  // decode credits must keep this queue from ever filling past its depth
  a_no_overrun : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !q_overrun);

endmodule

/* hw/cmdproc_top.sv */
`timescale 1ns/1ps
`include "cmdproc_params.svh"

module cmdproc_top (
  input  logic          i_clk,
  input  logic          i_rst_n,
  input  logic          i_cmd_valid,
  input  cmd_pkg::cmd_t i_cmd,
  output logic          o_cmd_credit,
  output logic          o_rsp_valid,
  output rsp_pkg::rsp_t o_rsp,
  input  logic          i_rsp_credit,
  output logic          o_overrun
);

  import cmd_pkg::*;
  import rsp_pkg::*;

  cmd_t head_cmd;     // command queue head
  logic cmd_empty;
  logic cmd_pop;
  logic uop_valid;
  uop_t uop;
  logic rsp_valid;
  rsp_t rsp;
  logic slot_credit;  // response queue slot freed

  credit_fifo #(
    .T     (cmd_t),
    .DEPTH (`CP_CMD_DEPTH)
  ) u_cmd_fifo (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_push    (i_cmd_valid),
    .i_data    (i_cmd),
    .i_pop     (cmd_pop),
    .o_data    (head_cmd),
    .o_empty   (cmd_empty),
    .o_full    (),
    .o_credit  (o_cmd_credit),
    .o_overrun (o_overrun)
  );

  cmd_decode u_decode (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_cmd         (head_cmd),
    .i_cmd_empty   (cmd_empty),
    .i_slot_credit (slot_credit),
    .o_pop         (cmd_pop),
    .o_uop_valid   (uop_valid),
    .o_uop         (uop)
  );

  alu_execute u_execute (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_uop_valid (uop_valid),
    .i_uop       (uop),
    .o_rsp_valid (rsp_valid),
    .o_rsp       (rsp)
  );

  rsp_result u_result (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_rsp_valid   (rsp_valid),
    .i_rsp         (rsp),
    .i_rsp_credit  (i_rsp_credit),
    .o_rsp_valid   (o_rsp_valid),
    .o_rsp         (o_rsp),
    .o_slot_credit (slot_credit)
  );

endmodule

/* verification/tb_cmdproc.sv */
`timescale 1ns/1ps
`include "cmdproc_params.svh"

module tb_cmdproc;

  import cmd_pkg::*;
  import rsp_pkg::*;

  localparam int MAX_VEC      = 64;
  localparam int STALL_CYCLES = 200;  // consumer holds back all credits this long
  localparam int SETTLE       = 40;

  logic i_clk;
  logic i_rst_n;
  logic i_cmd_valid;
  cmd_t i_cmd;
  logic o_cmd_credit;
  logic o_rsp_valid;
  rsp_t o_rsp;
  logic i_rsp_credit;
  logic o_overrun;

  logic [15:0] vec_mem [6*MAX_VEC];  // op, a, b, tag, result, status per vector
  int          nvec = 0;
  int          host_credits;  // host view of free command queue slots
  int          cmd_pulses;
  int          sent;
  int          rsp_grants;    // consumer credits still held by the DUT
  logic        release_en;    // consumer hands credits back at random
  logic        overrun_exp;
  rsp_t        exp_q [$];     // scoreboard, in command order

  cmdproc_top i_dut (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_cmd_valid  (i_cmd_valid),
    .i_cmd        (i_cmd),
    .o_cmd_credit (o_cmd_credit),
    .o_rsp_valid  (o_rsp_valid),
    .o_rsp        (o_rsp),
    .i_rsp_credit (i_rsp_credit),
    .o_overrun    (o_overrun)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  task automatic stop_run();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic protocol_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    stop_run();
  endtask

  task automatic check_rsp(input rsp_t got, input rsp_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: got tag %h result %h status %0d, exp tag %h result %h status %0d",
               $time, got.tag, got.result, got.status, exp.tag, exp.result, exp.status);
      stop_run();
    end
  endtask

  task automatic check_overrun(input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: overrun flag is %b, expected %b", $time, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      stop_run();
    end
  endtask

  function automatic cmd_t vec_cmd(input int idx);
    cmd_t c;
    c.op  = opcode_e'(vec_mem[6*idx][2:0]);
    c.a   = vec_mem[6*idx+1];
    c.b   = vec_mem[6*idx+2];
    c.tag = vec_mem[6*idx+3][`CP_TAG_W-1:0];
    return c;
  endfunction

  function automatic rsp_t vec_rsp(input int idx);
    rsp_t r;
    r.tag    = vec_mem[6*idx+3][`CP_TAG_W-1:0];
    r.result = vec_mem[6*idx+4];
    r.status = status_e'(vec_mem[6*idx+5][1:0]);
    return r;
  endfunction

  // one clock with outputs sampled at the falling edge before this cycle's inputs go out
  task automatic tick(input logic send, input cmd_t cmd);
    @(negedge i_clk);
    if (o_cmd_credit) begin
      host_credits++;
      cmd_pulses++;
    end
    if (o_rsp_valid) begin
      if (rsp_grants == 0) begin
        protocol_error("response sent while the consumer had granted no credit");
      end
      if (exp_q.size() == 0) begin
        protocol_error("response arrived with no command outstanding");
      end
      rsp_grants--;
      check_rsp(o_rsp, exp_q.pop_front());
    end
    check_overrun(o_overrun, overrun_exp);
    i_rsp_credit = 1'b0;
    if (release_en && rsp_grants < `CP_RSP_CREDITS && ($urandom % 3) == 0) begin
      i_rsp_credit = 1'b1;
      rsp_grants++;
    end
    i_cmd_valid = send;
    i_cmd       = cmd;
  endtask

  task automatic idle();
    tick(1'b0, '0);
  endtask

  task automatic push_vec(input int idx);
    tick(1'b1, vec_cmd(idx));  // caller makes sure a credit is held
    host_credits--;
    sent++;
    exp_q.push_back(vec_rsp(idx));
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      idle();
    end
    repeat (SETTLE) idle();  // late or duplicate responses would land here
  endtask

  initial begin
    int waited;
    int pulses_at;
    int sent_at;
    int k;
    void'($urandom(32'h375c));
    i_rst_n      = 1'b0;
    i_cmd_valid  = 1'b0;
    i_cmd        = '0;
    i_rsp_credit = 1'b0;
    host_credits = `CP_CMD_DEPTH;
    cmd_pulses   = 0;
    sent         = 0;
    rsp_grants   = `CP_RSP_CREDITS;
    release_en   = 1'b0;
    overrun_exp  = 1'b0;
    for (int i = 0; i < 6*MAX_VEC; i++) begin
      vec_mem[i] = 16'hffff;  // any op above 7 ends the list
    end
    $readmemh("verification/cmdproc_testdata.txt", vec_mem);
    k = 0;
    while (k < MAX_VEC && vec_mem[6*k] < 16'd8) begin
      k++;
    end
    if (k == 0) begin
      protocol_error("the data file holds no test vectors");
    end
    nvec = k;

    repeat (5) @(negedge i_clk);
    i_rst_n = 1'b1;
    check_flag("response valid after reset", o_rsp_valid, 1'b0);
    check_flag("command credit after reset", o_cmd_credit, 1'b0);
    check_overrun(o_overrun, 1'b0);

    // all opcodes with random gaps while the consumer keeps up
    release_en = 1'b1;
    for (int i = 0; i < nvec; i++) begin
      while (host_credits == 0) begin
        idle();
      end
      repeat ($urandom % 3) idle();
      push_vec(i);
    end
    drain();
    check_count("host credits after first pass", host_credits, `CP_CMD_DEPTH);

    // long output stall that makes the host run dry and wait
    release_en = 1'b0;
    waited     = 0;
    pulses_at  = cmd_pulses;
    sent_at    = sent;
    for (int i = 0; i < nvec; i++) begin
      while (host_credits == 0) begin
        if (waited == STALL_CYCLES) begin
          release_en = 1'b1;
        end
        idle();
        waited++;
      end
      push_vec(i);
    end
    check_flag("host blocked for the whole stall", waited > STALL_CYCLES, 1'b1);
    drain();
    check_count("command credits returned after stall", cmd_pulses - pulses_at,
                sent - sent_at);
    check_count("host credits after stall", host_credits, `CP_CMD_DEPTH);

    // fill everything and then push once without a credit
    release_en = 1'b0;
    waited     = 0;
    k          = 0;
    while (waited < 30) begin  // no credit for 30 cycles means the queue is full
      if (host_credits > 0) begin
        push_vec(k % nvec);
        k++;
        waited = 0;
      end else begin
        idle();
        waited++;
      end
    end
    tick(1'b1, vec_cmd(k % nvec));
    overrun_exp = 1'b1;  // flag shows from the next sample on
    idle();
    release_en = 1'b1;
    drain();
    check_count("host credits after overrun", host_credits, `CP_CMD_DEPTH);

    $display("=== PASS ===");
    $finish;
  end

  initial begin
    wait (nvec > 0);
    repeat (nvec * 40 + 2000) @(posedge i_clk);
    $display("timeout: run timed out waiting for responses after %0d cycles",
             nvec * 40 + 2000);
    stop_run();
  end

endmodule

/* verification/cmdproc_testdata.txt */
// columns (hex): op a b tag expected_result expected_status
// status 0 is ok, 1 is bad opcode; a line with op f ends the list
0 1234 0001 1 1235 0
0 ffff 0002 2 0001 0
0 8000 8000 3 0000 0
1 0005 0003 4 0002 0
1 0000 0001 5 ffff 0
1 1234 1234 6 0000 0
2 f0f0 ff00 7 f000 0
2 aaaa 5555 8 0000 0
3 f0f0 ff00 9 0ff0 0
3 1234 ffff a edcb 0
4 8000 000f b 0001 0
4 abcd 0004 c 0abc 0
4 ffff 0010 d ffff 0
4 1234 0021 e 091a 0
5 1111 2222 f 0000 1
6 1111 2222 0 0000 1
7 ffff ffff 1 0000 1
0 7fff 0001 2 8000 0
1 8000 0001 3 7fff 0
3 aaaa aaaa 4 0000 0
2 ffff 1357 5 1357 0
4 0f00 0008 6 000f 0
5 0000 0000 7 0000 1
0 0102 0304 8 0406 0
f 0000 0000 0 0000 0

/* filelist.f */
+incdir+common
common/cmd_pkg.sv
common/rsp_pkg.sv
hw/credit_fifo.sv
hw/cmd_decode.sv
hw/alu_execute.sv
hw/rsp_result.sv
hw/cmdproc_top.sv
verification/tb_cmdproc.sv

/* Makefile */
# Verilator build and run for the command processor testbench
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	  -f filelist.f --top-module tb_cmdproc -Mdir obj_dir -o Vtb_cmdproc

run: build
	./obj_dir/Vtb_cmdproc 2>&1 | tee $(LOG)
	@grep -qx "=== PASS ===" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
	  -f filelist.f --top-module cmdproc_top

clean:
	rm -rf obj_dir $(LOG)
